// ==== design/rename_pkg.sv ====
////////////////////////////////////////////////////////////
// rename package
// register counts and index types shared by the rename
// subsystem, the speculative map and the retire map
////////////////////////////////////////////////////////////

`default_nettype none

package rename_pkg;

    // architectural register file
    localparam int ARCH_REGS = 32;
    localparam int AREG_LEN  = 5;

    // physical register file, register 0 is the reset mapping
    localparam int PRF_SIZE = 64;
    localparam int PRF_LEN  = 6;

    // index of an architectural register
    typedef logic [AREG_LEN-1:0] areg_t;

    // index of a physical register
    typedef logic [PRF_LEN-1:0] preg_t;

    // one physical index per architectural register, indexed by areg_t
    typedef preg_t [ARCH_REGS-1:0] map_table_t;

endpackage

`default_nettype wire

// ==== design/rename_ifs.sv ====
////////////////////////////////////////////////////////////
// rename and commit interfaces
// rename_if carries the destination allocation handshake,
// commit_if carries the retire strobe and the freed preg
////////////////////////////////////////////////////////////

`default_nettype none

interface rename_if
    import rename_pkg::*;
();

    logic  valid;      // a rename is requested this cycle
    logic  ready;      // a free physical register is on offer
    areg_t dest_areg;
    preg_t dest_preg;

    // free list side, offers the head of the queue
    modport alloc (
        input  valid,
        output ready,
        output dest_preg
    );

    // map side, writes the new mapping on a handshake
    modport map (
        input valid,
        input ready,
        input dest_areg,
        input dest_preg
    );

endinterface

interface commit_if
    import rename_pkg::*;
();

    logic  valid;      // strobe, never back-pressured
    areg_t areg;
    preg_t preg;
    preg_t prev_preg;  // committed mapping that is being superseded

    modport retire (
        input  valid,
        input  areg,
        input  preg,
        output prev_preg
    );

    modport reclaim (
        input valid,
        input prev_preg
    );

endinterface

`default_nettype wire

// ==== design/rename_table.sv ====
////////////////////////////////////////////////////////////
// speculative rename table
// maps architectural to physical registers for renaming,
// reads both sources and the old destination mapping, and
// restores from the committed map on a flush
////////////////////////////////////////////////////////////

`default_nettype none

module rename_table
    import rename_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       reset,

    rename_if.map           ren,

    input  wire areg_t      src1_areg,
    input  wire areg_t      src2_areg,
    output preg_t           src1_preg,
    output preg_t           src2_preg,
    output preg_t           prev_preg,

    input  wire logic       flush,
    input  wire map_table_t restore_map
);

    map_table_t spec_map;
    logic       rename_fire;

    assign rename_fire = ren.valid && ren.ready;

    // lookups see the map before this cycle's write, so an instruction
    // that reads and writes the same register gets the older preg
    assign src1_preg = spec_map[src1_areg];
    assign src2_preg = spec_map[src2_areg];
    assign prev_preg = spec_map[ren.dest_areg];  // goes to the ROB for later freeing

    always_ff @(posedge clock) begin
        if (reset) begin
            spec_map <= '0;  // every areg starts on physical register 0
        end else if (flush) begin
            // throw away all speculative renames in one step
            spec_map <= restore_map;
        end else if (rename_fire) begin
            spec_map[ren.dest_areg] <= ren.dest_preg;
        end
    end

endmodule

`default_nettype wire

// ==== design/retire_table.sv ====
////////////////////////////////////////////////////////////
// retire rename table
// committed architectural map, hands the superseded preg
// to the free list and supplies the flush restore image
////////////////////////////////////////////////////////////

`default_nettype none

module retire_table
    import rename_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,

    commit_if.retire  cmt,

    output map_table_t retire_map
);

    map_table_t commit_map;

    // whole committed state, the speculative map reloads it on flush
    assign retire_map = commit_map;

    // mapping that the committing instruction replaces
    assign cmt.prev_preg = commit_map[cmt.areg];

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_map <= '0;
        end else if (cmt.valid) begin
            commit_map[cmt.areg] <= cmt.preg;  // commits arrive in program order
        end
    end

endmodule

`default_nettype wire

// ==== design/free_list.sv ====
////////////////////////////////////////////////////////////
// physical register free list
// circular queue of free pregs with a speculative head for
// renaming and a committed head for flush recovery
////////////////////////////////////////////////////////////

`default_nettype none

module free_list
    import rename_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,

    rename_if.alloc   ren,
    commit_if.reclaim cmt,

    input  wire logic flush
);

    preg_t queue [PRF_SIZE];

    preg_t spec_head;      // next preg handed to rename
    preg_t retire_head;    // position spec_head had at the last commit
    preg_t tail;           // next slot for a freed preg
    preg_t spec_count;     // free pregs seen by rename
    preg_t retire_count;   // free pregs in the committed state

    logic alloc;
    logic commit;
    logic reclaim;

    assign alloc   = ren.valid && ren.ready;
    assign commit  = cmt.valid;
    assign reclaim = cmt.valid && (cmt.prev_preg != '0);  // preg 0 never goes back

    assign ren.dest_preg = queue[spec_head];
    assign ren.ready     = (spec_count != '0) && !flush;

    // at most 63 pregs are ever free, so the tail cannot lap retire_head
    // and the entries between retire_head and spec_head stay intact
    always_ff @(posedge clock) begin
        if (reset) begin
            // entry i holds preg i, slot 0 is the first tail slot
            for (int i = 0; i < PRF_SIZE; i++) begin
                queue[i] <= preg_t'(i);
            end
            spec_head    <= preg_t'(1);
            retire_head  <= preg_t'(1);
            tail         <= '0;
            spec_count   <= preg_t'(PRF_SIZE - 1);
            retire_count <= preg_t'(PRF_SIZE - 1);
        end else begin
            if (reclaim) begin
                queue[tail] <= cmt.prev_preg;
                tail        <= tail + preg_t'(1);
            end

            if (commit) begin
                retire_head <= retire_head + preg_t'(1);
            end
            retire_count <= retire_count + preg_t'(reclaim) - preg_t'(commit);

            if (flush) begin
                // roll back to the committed allocation point
                spec_head  <= retire_head;
                spec_count <= retire_count;
            end else begin
                if (alloc) begin
                    spec_head <= spec_head + preg_t'(1);
                end
                spec_count <= spec_count + preg_t'(reclaim) - preg_t'(alloc);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/rename_unit.sv ====
////////////////////////////////////////////////////////////
// register rename unit
// single-issue rename with speculative map, retire map and
// free list, recovered to the committed state on flush
////////////////////////////////////////////////////////////

`default_nettype none

module rename_unit
    import rename_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,

    // rename request, one instruction per cycle
    input  wire logic  rename_valid,
    output logic       rename_ready,
    input  wire areg_t rename_dest_areg,
    input  wire areg_t rename_src1_areg,
    input  wire areg_t rename_src2_areg,
    output preg_t      rename_dest_preg,
    output preg_t      rename_prev_preg,
    output preg_t      rename_src1_preg,
    output preg_t      rename_src2_preg,

    // commit strobe from the ROB
    input  wire logic  commit_valid,
    input  wire areg_t commit_areg,
    input  wire preg_t commit_preg,
    output preg_t      commit_prev_preg,

    input  wire logic  flush
);

    rename_if   ren_bus ();
    commit_if   cmt_bus ();
    map_table_t restore_map;

    assign ren_bus.valid     = rename_valid;
    assign ren_bus.dest_areg = rename_dest_areg;
    assign rename_ready      = ren_bus.ready;
    assign rename_dest_preg  = ren_bus.dest_preg;

    assign cmt_bus.valid    = commit_valid;
    assign cmt_bus.areg     = commit_areg;
    assign cmt_bus.preg     = commit_preg;
    assign commit_prev_preg = cmt_bus.prev_preg;

    rename_table rename_table_i (
        .clock       (clock),
        .reset       (reset),
        .ren         (ren_bus),
        .src1_areg   (rename_src1_areg),
        .src2_areg   (rename_src2_areg),
        .src1_preg   (rename_src1_preg),
        .src2_preg   (rename_src2_preg),
        .prev_preg   (rename_prev_preg),
        .flush       (flush),
        .restore_map (restore_map)
    );

    retire_table retire_table_i (
        .clock      (clock),
        .reset      (reset),
        .cmt        (cmt_bus),
        .retire_map (restore_map)
    );

    free_list free_list_i (
        .clock (clock),
        .reset (reset),
        .ren   (ren_bus),
        .cmt   (cmt_bus),
        .flush (flush)
    );

endmodule

`default_nettype wire

// ==== bench/rename_asserts.sv ====
////////////////////////////////////////////////////////////
// free list assertions
// bound into free_list to check the counts, the handshake
// and that flush never meets a commit
////////////////////////////////////////////////////////////

`default_nettype none

module free_list_asserts
    import rename_pkg::*;
(
    input wire logic  clock,
    input wire logic  reset,
    input wire logic  flush,
    input wire logic  commit,
    input wire logic  alloc,
    input wire logic  ready,
    input wire preg_t dest_preg,
    input wire preg_t spec_count,
    input wire preg_t retire_count
);

    timeunit 1ns;
    timeprecision 100ps;

    // renames in flight only ever take pregs away from the committed pool
    spec_le_retire: assert property (@(posedge clock) disable iff (reset)
        spec_count <= retire_count);

    // a handshake never hands out preg 0 because it is never freed
    no_alloc_of_zero: assert property (@(posedge clock) disable iff (reset)
        alloc |-> dest_preg != 6'd0);

    no_flush_with_commit: assert property (@(posedge clock) disable iff (reset)
        !(flush && commit));

    ready_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(ready));

endmodule

bind free_list free_list_asserts free_list_asserts_i (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .commit       (commit),
    .alloc        (alloc),
    .ready        (ren.ready),
    .dest_preg    (ren.dest_preg),
    .spec_count   (spec_count),
    .retire_count (retire_count)
);

`default_nettype wire

// ==== bench/tb_rename_unit.sv ====
////////////////////////////////////////////////////////////
// rename unit testbench
// applies a table of rename, commit, flush and idle rows and
// checks every output just before the next rising edge
////////////////////////////////////////////////////////////

`default_nettype none

module tb_rename_unit
    import rename_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {OP_IDLE, OP_RENAME, OP_COMMIT, OP_FLUSH} op_t;

    // exp_val and care are indexed ready, dest, prev, src1, src2, commit prev
    typedef struct {
        op_t         op;
        areg_t       dest_areg;
        areg_t       src1_areg;
        areg_t       src2_areg;
        areg_t       commit_areg;
        preg_t       commit_preg;
        logic [5:0]  care;
        preg_t [5:0] exp_val;
    } row_t;

    logic  clock;
    logic  reset;
    logic  rename_valid;
    logic  rename_ready;
    areg_t rename_dest_areg;
    areg_t rename_src1_areg;
    areg_t rename_src2_areg;
    preg_t rename_dest_preg;
    preg_t rename_prev_preg;
    preg_t rename_src1_preg;
    preg_t rename_src2_preg;
    logic  commit_valid;
    areg_t commit_areg;
    preg_t commit_preg;
    preg_t commit_prev_preg;
    logic  flush;

    row_t  rows [$];
    int    cycles;
    int    limit;

    // expected state that is kept while the table is built
    preg_t spec_map [ARCH_REGS];
    preg_t cmt_map  [ARCH_REGS];
    preg_t free_q [$];      // free pregs in allocation order
    areg_t pend_areg [$];   // renames not yet committed with the oldest first
    preg_t pend_preg [$];

    rename_unit rename_unit_i (
        .clock            (clock),
        .reset            (reset),
        .rename_valid     (rename_valid),
        .rename_ready     (rename_ready),
        .rename_dest_areg (rename_dest_areg),
        .rename_src1_areg (rename_src1_areg),
        .rename_src2_areg (rename_src2_areg),
        .rename_dest_preg (rename_dest_preg),
        .rename_prev_preg (rename_prev_preg),
        .rename_src1_preg (rename_src1_preg),
        .rename_src2_preg (rename_src2_preg),
        .commit_valid     (commit_valid),
        .commit_areg      (commit_areg),
        .commit_preg      (commit_preg),
        .commit_prev_preg (commit_prev_preg),
        .flush            (flush)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("FAIL: see errors above");
            $fatal(1, "timeout, the run went past %0d cycles", limit);
        end
    end

    function automatic string field_name(input logic [2:0] k);
        case (k)
            3'd0:    return "rename_ready";
            3'd1:    return "rename_dest_preg";
            3'd2:    return "rename_prev_preg";
            3'd3:    return "rename_src1_preg";
            3'd4:    return "rename_src2_preg";
            default: return "commit_prev_preg";
        endcase
    endfunction

    // works out the outputs of one row and then steps the expected state
    task automatic add_row(input op_t op, input areg_t dest, input areg_t src1,
                           input areg_t src2);
        row_t r;
        r.op          = op;
        r.dest_areg   = dest;
        r.src1_areg   = src1;
        r.src2_areg   = src2;
        r.commit_areg = (op == OP_COMMIT) ? pend_areg[0] : 5'd0;
        r.commit_preg = (op == OP_COMMIT) ? pend_preg[0] : 6'd0;
        r.care        = 6'b111111;
        r.exp_val[0]  = preg_t'(free_q.size() != 0 && op != OP_FLUSH);
        r.exp_val[1]  = (free_q.size() != 0) ? free_q[0] : 6'd0;
        r.care[1]     = r.exp_val[0][0];   // dest_preg means nothing without ready
        r.exp_val[2]  = spec_map[dest];
        r.exp_val[3]  = spec_map[src1];
        r.exp_val[4]  = spec_map[src2];
        r.exp_val[5]  = cmt_map[r.commit_areg];
        case (op)
            OP_RENAME: begin
                if (free_q.size() != 0) begin
                    pend_areg.push_back(dest);
                    pend_preg.push_back(free_q[0]);
                    spec_map[dest] = free_q.pop_front();
                end
            end
            OP_COMMIT: begin
                if (cmt_map[r.commit_areg] != 6'd0) begin
                    free_q.push_back(cmt_map[r.commit_areg]);
                end
                cmt_map[r.commit_areg] = r.commit_preg;
                pend_areg.delete(0);
                pend_preg.delete(0);
            end
            OP_FLUSH: begin
                // uncommitted pregs go back to the front in their old order
                while (pend_preg.size() != 0) begin
                    free_q.push_front(pend_preg.pop_back());
                end
                pend_areg.delete();
                spec_map = cmt_map;
            end
            default: ;
        endcase
        rows.push_back(r);
    endtask

    task automatic build_table();
        areg_t d;
        d        = 5'd0;
        spec_map = '{default: 6'd0};
        cmt_map  = '{default: 6'd0};
        for (int p = 1; p < PRF_SIZE; p++) begin
            free_q.push_back(preg_t'(p));
        end
        add_row(OP_IDLE, 5'd0, 5'd3, 5'd7);     // reset mapping
        add_row(OP_RENAME, 5'd1, 5'd1, 5'd2);
        add_row(OP_RENAME, 5'd2, 5'd1, 5'd2);
        add_row(OP_RENAME, 5'd1, 5'd1, 5'd2);   // second rename of areg 1
        add_row(OP_IDLE, 5'd1, 5'd1, 5'd2);
        repeat (3) add_row(OP_COMMIT, 5'd0, 5'd0, 5'd0);
        add_row(OP_RENAME, 5'd3, 5'd1, 5'd3);
        add_row(OP_RENAME, 5'd1, 5'd1, 5'd3);
        add_row(OP_FLUSH, 5'd1, 5'd1, 5'd3);
        add_row(OP_IDLE, 5'd1, 5'd1, 5'd3);     // committed map is back
        // drain the free list so that the last rows stall with the request held
        for (int i = 0; i < 63; i++) begin
            if (free_q.size() != 0) begin
                d = areg_t'(i % 31 + 1);
            end
            add_row(OP_RENAME, d, d, d + 5'd1);
        end
        add_row(OP_COMMIT, d, d, d + 5'd1);
        add_row(OP_RENAME, d, d, d + 5'd1);     // gets the preg just freed
        while (pend_preg.size() != 0) begin
            add_row(OP_COMMIT, 5'd0, 5'd0, 5'd0);
        end
        repeat (4) add_row(OP_RENAME, 5'd5, 5'd5, 5'd6);
    endtask

    task automatic apply_row(input row_t r, input int n);
        preg_t [5:0] got;
        rename_valid     = (r.op == OP_RENAME);
        rename_dest_areg = r.dest_areg;
        rename_src1_areg = r.src1_areg;
        rename_src2_areg = r.src2_areg;
        commit_valid     = (r.op == OP_COMMIT);
        commit_areg      = r.commit_areg;
        commit_preg      = r.commit_preg;
        flush            = (r.op == OP_FLUSH);
        #19;
        got = {commit_prev_preg, rename_src2_preg, rename_src1_preg,
               rename_prev_preg, rename_dest_preg, preg_t'(rename_ready)};
        for (logic [2:0] k = 0; k < 6; k++) begin
            if (r.care[k]) begin
                assert (got[k] === r.exp_val[k]) else begin
                    $display("error at %0t: row %0d %s is %0d, expected %0d",
                             $time, n, field_name(k), got[k], r.exp_val[k]);
                    $display("FAIL: see errors above");
                    $fatal(1, "output mismatch");
                end
            end
        end
        @(negedge clock);
    endtask

    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        rename_valid     = 1'b0;
        rename_dest_areg = 5'd0;
        rename_src1_areg = 5'd0;
        rename_src2_areg = 5'd0;
        commit_valid     = 1'b0;
        commit_areg      = 5'd0;
        commit_preg      = 6'd0;
        flush            = 1'b0;
        cycles           = 0;
        build_table();
        limit = 2 * rows.size() + 100;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        foreach (rows[n]) begin
            apply_row(rows[n], n);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/rename_pkg.sv
design/rename_ifs.sv
design/rename_table.sv
design/retire_table.sv
design/free_list.sv
design/rename_unit.sv
bench/rename_asserts.sv
bench/tb_rename_unit.sv

// ==== run.sh ====
#!/bin/sh
# builds the rename unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_rename_unit -Mdir obj_dir -f tb.f

./obj_dir/Vtb_rename_unit
